//--- Makefile
# Verilator build and run of the apple1_io testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module apple1_io_tb \
		-f filelist.f --Mdir obj_dir -o sim
	./obj_dir/sim | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- design/apple1_io.sv
// Apple 1 keyboard and display I/O
`timescale 1ns/1ps

module apple1_io
    import apple1_pkg::*;
#(
    parameter int CLKS_PER_BIT = 217  // 115200 baud at 25 MHz
) (
    input  logic     clk25,
    input  logic     rst,
    input  logic     uart_rx,   // serial key input
    output logic     uart_tx,   // serial display output
    output logic     uart_cts,  // high while a key waits
    input  logic     ps2_clk,
    input  logic     ps2_din,
    input  bus_req_t bus,       // cpu register access
    output bus_rsp_t rsp
);

    key_evt_t   uart_key;
    key_evt_t   ps2_key;
    key_evt_t   kbd_wr;   // arbitrated write into the KBD latch
    logic       tx_start;
    logic [7:0] tx_data;
    logic       tx_busy;
    logic       key_ready;

    assign uart_cts = key_ready;

    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) uart_rx_i (
        .clk25(clk25),
        .rst  (rst),
        .rx   (uart_rx),
        .key  (uart_key)
    );

    ps2_keyboard ps2_keyboard_i (
        .clk25  (clk25),
        .rst    (rst),
        .ps2_clk(ps2_clk),
        .ps2_din(ps2_din),
        .key    (ps2_key)
    );

    key_arbiter key_arbiter_i (
        .clk25   (clk25),
        .rst     (rst),
        .uart_key(uart_key),
        .ps2_key (ps2_key),
        .kbd_wr  (kbd_wr)
    );

    pia_6821 pia_6821_i (
        .clk25    (clk25),
        .rst      (rst),
        .kbd_wr   (kbd_wr),
        .bus      (bus),
        .rsp      (rsp),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_busy  (tx_busy),
        .key_ready(key_ready)
    );

    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) uart_tx_i (
        .clk25(clk25),
        .rst  (rst),
        .start(tx_start),
        .data (tx_data),
        .tx   (uart_tx),
        .busy (tx_busy)
    );

endmodule

//--- design/apple1_pkg.sv
// Apple 1 I/O shared types
package apple1_pkg;

    // ascii width of a key code
    localparam int KEY_W = 7;

    // pia register select, D010..D013
    localparam logic [1:0] REG_KBD   = 2'd0;  // key data, ready in bit 7
    localparam logic [1:0] REG_KBDCR = 2'd1;  // keyboard control
    localparam logic [1:0] REG_DSP   = 2'd2;  // display data, busy in bit 7
    localparam logic [1:0] REG_DSPCR = 2'd3;  // display control

    // one-cycle key event from a receiver
    typedef struct packed {
        logic             strobe;  // event valid this cycle
        logic [KEY_W-1:0] ascii;   // upper-case ascii code
    } key_evt_t;

    // cpu side register access
    typedef struct packed {
        logic       stb;    // single-cycle access strobe
        logic       we;     // 1 = write
        logic [1:0] addr;   // register select
        logic [7:0] wdata;  // write data
    } bus_req_t;

    // registered read response
    typedef struct packed {
        logic       valid;  // one cycle after a read strobe
        logic [7:0] rdata;
    } bus_rsp_t;

endpackage

//--- design/key_arbiter.sv
// Key source arbiter
`timescale 1ns/1ps

module key_arbiter
    import apple1_pkg::*;
(
    input  logic     clk25,
    input  logic     rst,
    input  key_evt_t uart_key,
    input  key_evt_t ps2_key,
    output key_evt_t kbd_wr
);

    logic             pend_vld;   // losing ps2 event held here
    logic [KEY_W-1:0] pend_code;

    always_ff @(posedge clk25) begin
        if (rst) begin
            kbd_wr   <= '0;
            pend_vld <= 1'b0;
        end else begin
            kbd_wr.strobe <= 1'b0;
            if (uart_key.strobe) begin
                kbd_wr <= uart_key;  // serial has priority
                if (ps2_key.strobe) pend_vld <= 1'b1;
            end else if (ps2_key.strobe) begin
                kbd_wr <= ps2_key;
            end else if (pend_vld) begin
                kbd_wr   <= '{strobe: 1'b1, ascii: pend_code};  // first free cycle
                pend_vld <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk25) begin
        if (uart_key.strobe && ps2_key.strobe) begin
            pend_code <= ps2_key.ascii;
        end
    end

    // one slot is enough, ps2 frames are spaced far apart
    assert property (@(posedge clk25) disable iff (rst) ps2_key.strobe |-> !pend_vld);

endmodule

//--- design/pia_6821.sv
// PIA register window
`timescale 1ns/1ps

module pia_6821
    import apple1_pkg::*;
(
    input  logic       clk25,
    input  logic       rst,
    input  key_evt_t   kbd_wr,
    input  bus_req_t   bus,
    output bus_rsp_t   rsp,
    output logic       tx_start,
    output logic [7:0] tx_data,
    input  logic       tx_busy,
    output logic       key_ready
);

    logic [KEY_W-1:0] kbd;      // last key latched
    logic             ready;    // key waiting to be read
    logic [6:0]       kbdcr;    // bit 7 is the ready flag
    logic [6:0]       dspcr;    // bit 7 reads 0
    logic             rd;
    logic             wr;
    logic [7:0]       rd_mux;

    assign rd        = bus.stb & ~bus.we;
    assign wr        = bus.stb & bus.we;
    assign key_ready = ready;

    always_comb begin
        case (bus.addr)
            REG_KBD:   rd_mux = {ready, kbd};
            REG_KBDCR: rd_mux = {ready, kbdcr};
            REG_DSP:   rd_mux = {tx_busy, 7'h00};  // only busy is visible
            default:   rd_mux = {1'b0, dspcr};
        endcase
    end

    always_ff @(posedge clk25) begin
        if (rst) begin
            ready    <= 1'b0;
            kbdcr    <= '0;
            dspcr    <= '0;
            tx_start <= 1'b0;
            rsp      <= '0;
        end else begin
            rsp      <= '{valid: rd, rdata: rd_mux};
            tx_start <= 1'b0;
            if (rd && bus.addr == REG_KBD) ready <= 1'b0;  // read acknowledges
            if (kbd_wr.strobe) ready <= 1'b1;               // new key wins over the clear
            if (wr) begin
                case (bus.addr)
                    REG_KBDCR: kbdcr <= bus.wdata[6:0];
                    REG_DSP:   tx_start <= ~tx_busy;  // dropped while sending
                    REG_DSPCR: dspcr <= bus.wdata[6:0];
                    default:   ;                      // KBD is read only
                endcase
            end
        end
    end

    // latch and outgoing byte
    always_ff @(posedge clk25) begin
        if (kbd_wr.strobe) kbd <= kbd_wr.ascii;
        if (wr && bus.addr == REG_DSP && !tx_busy) begin
            tx_data <= {1'b0, bus.wdata[6:0]};  // 7-bit terminal
        end
    end

    // a response always answers a read one cycle earlier
    assert property (@(posedge clk25) disable iff (rst)
        rsp.valid |-> $past(bus.stb && !bus.we));

endmodule

//--- design/ps2_keyboard.sv
// PS/2 keyboard receiver
`timescale 1ns/1ps

module ps2_keyboard
    import apple1_pkg::*;
(
    input  logic     clk25,
    input  logic     rst,
    input  logic     ps2_clk,
    input  logic     ps2_din,
    output key_evt_t key
);

    logic [2:0]     clk_q;     // [1:0] synchronizer, [2] previous sample
    logic [1:0]     din_q;
    logic           fall;      // falling ps2 clock edge
    logic           din_s;
    logic [3:0]     bit_cnt;   // bits of the frame already taken
    logic [9:0]     shift;     // start, data, parity
    logic           frame_ok;
    logic           brk;       // last code was F0
    logic [KEY_W:0] map;       // {mapped, ascii}

    // set-2 make code to ascii, msb flags a known key
    function automatic logic [KEY_W:0] scan2ascii(input logic [7:0] sc);
        logic [KEY_W:0] m;
        m = '0;
        case (sc)
            8'h1c: m = {1'b1, 7'h41};  // A
            8'h32: m = {1'b1, 7'h42};
            8'h21: m = {1'b1, 7'h43};
            8'h23: m = {1'b1, 7'h44};
            8'h24: m = {1'b1, 7'h45};
            8'h2b: m = {1'b1, 7'h46};
            8'h34: m = {1'b1, 7'h47};
            8'h33: m = {1'b1, 7'h48};
            8'h43: m = {1'b1, 7'h49};
            8'h3b: m = {1'b1, 7'h4a};
            8'h42: m = {1'b1, 7'h4b};
            8'h4b: m = {1'b1, 7'h4c};
            8'h3a: m = {1'b1, 7'h4d};
            8'h31: m = {1'b1, 7'h4e};
            8'h44: m = {1'b1, 7'h4f};
            8'h4d: m = {1'b1, 7'h50};
            8'h15: m = {1'b1, 7'h51};
            8'h2d: m = {1'b1, 7'h52};
            8'h1b: m = {1'b1, 7'h53};
            8'h2c: m = {1'b1, 7'h54};
            8'h3c: m = {1'b1, 7'h55};
            8'h2a: m = {1'b1, 7'h56};
            8'h1d: m = {1'b1, 7'h57};
            8'h22: m = {1'b1, 7'h58};
            8'h35: m = {1'b1, 7'h59};
            8'h1a: m = {1'b1, 7'h5a};  // Z
            8'h45: m = {1'b1, 7'h30};  // 0
            8'h16: m = {1'b1, 7'h31};
            8'h1e: m = {1'b1, 7'h32};
            8'h26: m = {1'b1, 7'h33};
            8'h25: m = {1'b1, 7'h34};
            8'h2e: m = {1'b1, 7'h35};
            8'h36: m = {1'b1, 7'h36};
            8'h3d: m = {1'b1, 7'h37};
            8'h3e: m = {1'b1, 7'h38};
            8'h46: m = {1'b1, 7'h39};  // 9
            8'h29: m = {1'b1, 7'h20};  // space
            8'h5a: m = {1'b1, 7'h0d};  // enter gives CR
            default: m = '0;           // no event for anything else
        endcase
        return m;
    endfunction

    assign fall  = clk_q[2] & ~clk_q[1];
    assign din_s = din_q[1];
    // start low, stop high (arriving now), odd parity over data and parity bit
    assign frame_ok = !shift[0] && din_s && (^shift[9:1]);
    assign map      = scan2ascii(shift[8:1]);

    always_ff @(posedge clk25) begin
        if (rst) begin
            clk_q   <= 3'b111;  // bus idles high
            din_q   <= 2'b11;
            bit_cnt <= '0;
            brk     <= 1'b0;
            key     <= '0;
        end else begin
            clk_q      <= {clk_q[1:0], ps2_clk};
            din_q      <= {din_q[0], ps2_din};
            key.strobe <= 1'b0;
            if (fall) begin
                if (bit_cnt == 4'd10) begin  // stop bit on this edge
                    bit_cnt <= '0;
                    if (frame_ok) begin
                        if (shift[8:1] == 8'hf0) begin
                            brk <= 1'b1;  // next code is a release
                        end else if (brk) begin
                            brk <= 1'b0;  // release swallowed
                        end else if (map[KEY_W]) begin
                            key <= '{strobe: 1'b1, ascii: map[KEY_W-1:0]};
                        end
                    end
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // frame shifter, lsb first
    always_ff @(posedge clk25) begin
        if (fall && bit_cnt != 4'd10) begin
            shift <= {din_s, shift[9:1]};
        end
    end

    // an event is one cycle wide, a frame takes far longer
    assert property (@(posedge clk25) disable iff (rst) key.strobe |=> !key.strobe);

endmodule

//--- design/uart_rx.sv
// Serial key receiver
`timescale 1ns/1ps

module uart_rx
    import apple1_pkg::*;
#(
    parameter int CLKS_PER_BIT = 217  // baud divisor
) (
    input  logic     clk25,
    input  logic     rst,
    input  logic     rx,
    output key_evt_t key
);

    localparam int CW = $clog2(CLKS_PER_BIT + 1);

    typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

    state_t           state;
    logic [1:0]       rx_sync;  // 2-flop synchronizer, idles high
    logic             rx_s;
    logic [CW-1:0]    cnt;      // clocks within the current bit
    logic [2:0]       bit_idx;
    logic [7:0]       shift;    // data bits, lsb first
    logic [KEY_W-1:0] code;

    assign rx_s = rx_sync[1];

    // apple 1 only knows upper case
    always_comb begin
        code = shift[KEY_W-1:0];
        if (code >= 7'h61 && code <= 7'h7a) begin
            code[5] = 1'b0;
        end
    end

    always_ff @(posedge clk25) begin
        if (rst) begin
            rx_sync <= 2'b11;
            state   <= S_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            key     <= '0;
        end else begin
            rx_sync    <= {rx_sync[0], rx};
            key.strobe <= 1'b0;
            case (state)
                S_IDLE: begin
                    cnt <= '0;
                    if (!rx_s) state <= S_START;  // falling start edge
                end
                S_START: begin
                    if (cnt == CW'(CLKS_PER_BIT / 2 - 1)) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? S_IDLE : S_DATA;  // glitch, not a start bit
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_DATA: begin
                    if (cnt == CW'(CLKS_PER_BIT - 1)) begin  // mid-bit
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= S_STOP;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin  // S_STOP
                    if (cnt == CW'(CLKS_PER_BIT - 1)) begin
                        state <= S_IDLE;
                        if (rx_s) key <= '{strobe: 1'b1, ascii: code};  // framing error drops it
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // data shift register
    always_ff @(posedge clk25) begin
        if (state == S_DATA && cnt == CW'(CLKS_PER_BIT - 1)) begin
            shift <= {rx_s, shift[7:1]};
        end
    end

endmodule

//--- design/uart_tx.sv
// Serial display transmitter
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 217  // baud divisor
) (
    input  logic       clk25,
    input  logic       rst,
    input  logic       start,
    input  logic [7:0] data,
    output logic       tx,
    output logic       busy
);

    localparam int CW = $clog2(CLKS_PER_BIT + 1);

    logic          active;   // frame in progress
    logic [CW-1:0] cnt;      // clocks within the current bit
    logic [3:0]    bit_cnt;  // 0 = start bit, 9 = stop bit
    logic [8:0]    shift;    // data then stop, lsb first

    // start counts as busy so a back-to-back write is refused
    assign busy = active | start;

    always_ff @(posedge clk25) begin
        if (rst) begin
            tx      <= 1'b1;  // line idles high
            active  <= 1'b0;
            cnt     <= '0;
            bit_cnt <= '0;
        end else if (!active) begin
            if (start) begin
                tx      <= 1'b0;  // start bit
                active  <= 1'b1;
                cnt     <= '0;
                bit_cnt <= '0;
            end
        end else if (cnt == CW'(CLKS_PER_BIT - 1)) begin
            cnt <= '0;
            if (bit_cnt == 4'd9) begin
                active <= 1'b0;  // end of stop bit, tx already high
            end else begin
                tx      <= shift[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // payload shifter
    always_ff @(posedge clk25) begin
        if (!active && start) begin
            shift <= {1'b1, data};
        end else if (active && cnt == CW'(CLKS_PER_BIT - 1)) begin
            shift <= {1'b1, shift[8:1]};
        end
    end

endmodule

//--- filelist.f
design/apple1_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/ps2_keyboard.sv
design/key_arbiter.sv
design/pia_6821.sv
design/apple1_io.sv
tests/apple1_io_tb.sv

//--- tests/apple1_io_tb.sv
// Apple 1 I/O testbench
`timescale 1ns/1ps

module apple1_io_tb
    import apple1_pkg::*;
;

    localparam int CLKS_PER_BIT = 16;
    localparam int PS2_BIT      = 16;                   // system clocks per ps2 bit
    localparam int SER_CYC      = 11 * CLKS_PER_BIT;    // serial frame plus gap
    localparam int PS2_CYC      = 12 * PS2_BIT;         // ps2 frame plus gap
    localparam int TEST_CYC     = 5 * SER_CYC + 6 * PS2_CYC + 200;  // two rx and three tx slots
    localparam int LIMIT        = TEST_CYC * 12 / 10;   // 20 percent margin

    // set-2 make codes for A..Z, 0..9 and space in KEY_CHARS order
    localparam logic [8*37-1:0] SET2_CODES = {
        64'h1c_32_21_23_24_2b_34_33, 64'h43_3b_42_4b_3a_31_44_4d,
        64'h15_2d_1b_2c_3c_2a_1d_22, 64'h35_1a_45_16_1e_26_25_2e,
        40'h36_3d_3e_46_29
    };
    localparam logic [8*37-1:0] KEY_CHARS = "ABCDEFGHIJKLMNOPQRSTUVWXYZ0123456789 ";

    logic       clk25;
    logic       rst;
    logic       uart_rx;
    logic       uart_tx;
    logic       uart_cts;
    logic       ps2_clk;
    logic       ps2_din;
    bus_req_t   bus;
    bus_rsp_t   rsp;
    integer     seed = 78164;
    int         cycles = 0;
    int         frames_seen = 0;
    logic [7:0] exp_q[$];    // display chars still owed by uart_tx

    apple1_io #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) apple1_io_i (
        .clk25   (clk25),
        .rst     (rst),
        .uart_rx (uart_rx),
        .uart_tx (uart_tx),
        .uart_cts(uart_cts),
        .ps2_clk (ps2_clk),
        .ps2_din (ps2_din),
        .bus     (bus),
        .rsp     (rsp)
    );

    initial begin
        clk25 = 1'b0;
        forever #5 clk25 = ~clk25;
    end

    // apple 1 wants upper case with bit 7 dropped
    function automatic logic [6:0] ref_uart_key(input logic [7:0] b);
        logic [6:0] c;
        c = b[6:0];
        if (c >= 7'h61 && c <= 7'h7a) c = c - 7'h20;
        return c;
    endfunction

    // {mapped, ascii} or zero for unknown codes
    function automatic logic [7:0] ref_ps2_ascii(input logic [7:0] sc);
        logic [7:0] res;
        int         i;
        res = 8'h00;
        if (sc == 8'h5a) res = 8'h8d;  // enter gives CR
        for (i = 0; i < 37; i++) begin
            if (SET2_CODES[8*(36-i) +: 8] == sc) res = {1'b1, KEY_CHARS[8*(36-i) +: 7]};
        end
        return res;
    endfunction

    function automatic logic [7:0] ref_kbd(input logic ready, input logic [6:0] code);
        return {ready, code};
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_rsp(input string name, input bus_rsp_t got, input bus_rsp_t exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_char(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] t=%0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk25);
    endtask

    // 8N1 frame with lsb first
    task automatic send_serial(input logic [7:0] b);
        logic [9:0] frame;
        int         i;
        frame = {1'b1, b, 1'b0};
        @(posedge clk25);
        for (i = 0; i < 10; i++) begin
            uart_rx <= frame[i];
            wait_cycles(CLKS_PER_BIT);
        end
        wait_cycles(CLKS_PER_BIT);  // idle gap with the line already high
    endtask

    // data changes while ps2_clk is high and the device samples on the fall
    task automatic send_ps2(input logic [7:0] sc, input logic good_parity);
        logic [10:0] frame;
        int          i;
        frame = {1'b1, good_parity ? ~^sc : ^sc, sc, 1'b0};
        @(posedge clk25);
        for (i = 0; i < 11; i++) begin
            ps2_din <= frame[i];
            wait_cycles(PS2_BIT / 4);
            ps2_clk <= 1'b0;
            wait_cycles(PS2_BIT / 2);
            ps2_clk <= 1'b1;
            wait_cycles(PS2_BIT / 4);
        end
        ps2_din <= 1'b1;
        wait_cycles(PS2_BIT);
    endtask

    task automatic bus_write(input logic [1:0] addr, input logic [7:0] data);
        @(posedge clk25);
        bus <= '{stb: 1'b1, we: 1'b1, addr: addr, wdata: data};
        @(posedge clk25);
        bus <= '0;
    endtask

    // rsp is registered one cycle after the strobe
    task automatic bus_read(input logic [1:0] addr, output bus_rsp_t r);
        @(posedge clk25);
        bus <= '{stb: 1'b1, we: 1'b0, addr: addr, wdata: 8'h00};
        @(posedge clk25);
        bus <= '0;
        @(negedge clk25);
        r = rsp;
    endtask

    // poll KBDCR until the ready flag shows
    task automatic wait_key;
        bus_rsp_t r;
        r = '0;
        while (!r.rdata[7]) bus_read(REG_KBDCR, r);
    endtask

    // decode every uart_tx frame against the expected queue
    initial begin : tx_monitor
        logic [7:0] got;
        int         i;
        got = '0;
        wait (rst === 1'b0);
        forever begin
            @(negedge clk25);
            if (uart_tx == 1'b0) begin  // start bit
                repeat (CLKS_PER_BIT / 2) @(negedge clk25);
                check_bit("uart_tx start bit", uart_tx, 1'b0);
                for (i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk25);
                    got[i] = uart_tx;
                end
                repeat (CLKS_PER_BIT) @(negedge clk25);
                check_bit("uart_tx stop bit", uart_tx, 1'b1);
                if (exp_q.size() == 0) begin
                    fail_run("a frame appeared on uart_tx while no character was expected");
                end else begin
                    check_char("uart_tx frame", got, exp_q.pop_front());
                    frames_seen++;
                end
            end
        end
    end

    always @(posedge clk25) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) fail_run($sformatf("timeout, run exceeded %0d cycles", LIMIT));
    end

    initial begin : main
        bus_rsp_t   r;
        logic [7:0] b;
        logic [7:0] d;
        logic [7:0] m;
        int         v;
        rst     = 1'b1;
        uart_rx = 1'b1;
        ps2_clk = 1'b1;
        ps2_din = 1'b1;
        bus     = '0;
        wait_cycles(4);
        rst <= 1'b0;

        // idle state after reset
        @(negedge clk25);
        check_bit("uart_tx", uart_tx, 1'b1);
        check_bit("uart_cts", uart_cts, 1'b0);
        bus_read(REG_KBDCR, r);
        check_bit("KBDCR ready", r.rdata[7], 1'b0);

        // random lower-case serial key
        v = $unsigned($random(seed)) % 26;
        b = 8'h61 + 8'(v);
        send_serial(b);
        wait_key();
        check_bit("uart_cts", uart_cts, 1'b1);
        bus_read(REG_KBD, r);
        check_rsp("KBD", r, bus_rsp_t'{valid: 1'b1, rdata: ref_kbd(1'b1, ref_uart_key(b))});
        bus_read(REG_KBDCR, r);
        check_bit("KBDCR ready after read", r.rdata[7], 1'b0);
        check_bit("uart_cts after read", uart_cts, 1'b0);

        // make then break gives one key
        send_ps2(8'h33, 1'b1);
        wait_key();
        bus_read(REG_KBD, r);
        m = ref_ps2_ascii(8'h33);
        check_rsp("KBD", r, bus_rsp_t'{valid: 1'b1, rdata: ref_kbd(1'b1, m[6:0])});
        send_ps2(8'hf0, 1'b1);
        send_ps2(8'h33, 1'b1);
        wait_cycles(20);
        bus_read(REG_KBDCR, r);
        check_bit("KBDCR ready after break", r.rdata[7], 1'b0);
        send_ps2(8'h76, 1'b1);  // escape is not in the table
        wait_cycles(20);
        bus_read(REG_KBDCR, r);
        check_bit("KBDCR ready after unmapped code", r.rdata[7], 1'b0);
        send_ps2(8'h1c, 1'b0);  // parity error
        wait_cycles(20);
        bus_read(REG_KBDCR, r);
        check_bit("KBDCR ready after parity error", r.rdata[7], 1'b0);

        // latest event overwrites the latch
        send_serial(8'h71);
        send_ps2(8'h45, 1'b1);
        wait_key();
        bus_read(REG_KBD, r);
        m = ref_ps2_ascii(8'h45);
        check_rsp("KBD latest", r, bus_rsp_t'{valid: 1'b1, rdata: ref_kbd(1'b1, m[6:0])});

        // display write and then one dropped while busy
        d = 8'($random(seed));
        exp_q.push_back({1'b0, d[6:0]});
        bus_write(REG_DSP, d);
        bus_read(REG_DSP, r);
        check_bit("DSP busy", r.rdata[7], 1'b1);
        bus_write(REG_DSP, ~d);
        while (frames_seen < 1) @(posedge clk25);
        wait_cycles(2 * 10 * CLKS_PER_BIT);  // room for a stray frame
        check_bit("single display frame", frames_seen == 1, 1'b1);
        d = 8'($random(seed));
        bus_write(REG_DSPCR, d);
        bus_read(REG_DSPCR, r);
        check_rsp("DSPCR", r, bus_rsp_t'{valid: 1'b1, rdata: {1'b0, d[6:0]}});

        $display("TB PASSED");
        $finish;
    end

endmodule
